// ==== source/lsu_pkg.sv ====
package lsu_pkg;

  // Byte address as seen by the load/store unit and the bus.
  typedef logic [31:0] addr_t;

  // One 32-bit data word.
  typedef logic [31:0] data_t;

  // Byte-lane write enables, one bit per byte of data_t.
  typedef logic [3:0] strb_t;

  // Access size code: 0 is byte, 1 is halfword, 2 is word.
  typedef logic [1:0] access_size_t;

  // SRAM holds 256 words, which is 1 KiB.
  localparam int MEM_WORDS = 256;

  // Word index bits, taken from address bits [9:2].
  localparam int MEM_INDEX_BITS = 8;

  // Cycles from read-address acceptance until read data is valid.
  localparam int READ_LATENCY = 2;

endpackage

// ==== source/axi_bus_if.sv ====
`timescale 1ns/1ps

interface axi_bus_if (
  input logic clock
);

  lsu_pkg::addr_t araddr;
  logic arvalid;
  logic arready;

  lsu_pkg::data_t rdata;
  logic rvalid;
  logic rready;

  lsu_pkg::addr_t awaddr;
  logic awvalid;
  logic awready;

  lsu_pkg::data_t wdata;
  lsu_pkg::strb_t wstrb;
  logic wvalid;
  logic wready;

  logic bvalid;
  logic bready;

  modport master (
    input clock,
    output araddr, arvalid, input arready,
    input rdata, rvalid, output rready,
    output awaddr, awvalid, input awready,
    output wdata, wstrb, wvalid, input wready,
    input bvalid, output bready
  );

  modport slave (
    input clock,
    input araddr, arvalid, output arready,
    output rdata, rvalid, input rready,
    input awaddr, awvalid, output awready,
    input wdata, wstrb, wvalid, output wready,
    output bvalid, input bready
  );

endinterface

// ==== source/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit (
  input logic clock,
  input logic reset,
  input logic req_valid,
  output logic req_ready,
  input lsu_pkg::addr_t req_addr,
  input lsu_pkg::access_size_t req_size,
  input logic req_signed,
  input logic req_write,
  input lsu_pkg::data_t req_wdata,
  output logic resp_valid,
  output lsu_pkg::data_t resp_rdata,
  axi_bus_if.master bus
);

  typedef enum logic {
    idle,
    busy
  } lsu_state_e;

  lsu_state_e state;
  lsu_state_e next_state;

  logic accept;
  lsu_pkg::strb_t size_mask;
  lsu_pkg::strb_t store_strb;
  lsu_pkg::data_t store_data;
  lsu_pkg::access_size_t load_size;
  logic load_signed;

  // Moves the addressed bytes down to bit 0 and extends them to a full word.
  function automatic lsu_pkg::data_t extend_load(
    input lsu_pkg::data_t word,
    input logic [1:0] offset,
    input lsu_pkg::access_size_t size,
    input logic sign
  );
    lsu_pkg::data_t shifted;
    shifted = word >> {offset, 3'b000};
    case (size)
      2'd0: extend_load = sign ? {{24{shifted[7]}}, shifted[7:0]} : {24'h0, shifted[7:0]};
      2'd1: extend_load = sign ? {{16{shifted[15]}}, shifted[15:0]} : {16'h0, shifted[15:0]};
      default: extend_load = shifted;
    endcase
  endfunction

  assign accept = (state == idle) && req_valid && req_ready;

  always_comb begin
    case (req_size)
      2'd0: size_mask = 4'b0001;
      2'd1: size_mask = 4'b0011;
      default: size_mask = 4'b1111;
    endcase
  end

  assign store_strb = size_mask << req_addr[1:0];
  assign store_data = req_wdata << {req_addr[1:0], 3'b000}; // Data lands in its byte lanes.

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      idle: begin
        if (accept) begin
          next_state = busy;
        end
      end
      busy: begin
        if (bus.rvalid || bus.bvalid) begin
          next_state = idle;
        end
      end
      default: next_state = idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      req_ready <= 1'b1;
      resp_valid <= 1'b0;
      bus.arvalid <= 1'b0;
      bus.awvalid <= 1'b0;
      bus.wvalid <= 1'b0;
      bus.rready <= 1'b0;
      bus.bready <= 1'b0;
    end else begin
      case (state)
        idle: begin
          bus.rready <= 1'b0;
          bus.bready <= 1'b0;
          resp_valid <= accept && req_write; // Stores finish from the caller's view at once.
          if (accept) begin
            req_ready <= 1'b0;
            bus.arvalid <= !req_write;
            bus.awvalid <= req_write;
            bus.wvalid <= req_write;
          end
        end
        busy: begin
          resp_valid <= 1'b0;
          if (bus.arready) begin
            bus.arvalid <= 1'b0;
          end
          if (bus.awready) begin
            bus.awvalid <= 1'b0;
          end
          if (bus.wready) begin
            bus.wvalid <= 1'b0;
          end
          if (bus.rvalid) begin
            bus.rready <= 1'b1;
            resp_valid <= 1'b1;
            req_ready <= 1'b1;
          end
          if (bus.bvalid) begin
            bus.bready <= 1'b1;
            req_ready <= 1'b1;
          end
        end
        default: req_ready <= 1'b1;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      bus.araddr <= req_addr;
      bus.awaddr <= req_addr;
      bus.wdata <= store_data;
      bus.wstrb <= store_strb;
      load_size <= req_size;
      load_signed <= req_signed;
    end
    if (state == busy && bus.rvalid) begin
      resp_rdata <= extend_load(bus.rdata, bus.araddr[1:0], load_size, load_signed);
    end
  end

endmodule

// ==== source/axi_sram.sv ====
`timescale 1ns/1ps

module axi_sram (
  input logic clock,
  input logic reset,
  axi_bus_if.slave bus
);

  typedef enum logic [2:0] {
    sram_idle,
    read_wait,
    read_resp,
    write_collect,
    write_resp
  } sram_state_e;

  sram_state_e state;

  logic [$clog2(lsu_pkg::READ_LATENCY + 1) - 1:0] delay_count;
  logic [lsu_pkg::MEM_INDEX_BITS - 1:0] read_index;
  logic [lsu_pkg::MEM_INDEX_BITS - 1:0] write_index;
  lsu_pkg::data_t write_data;
  lsu_pkg::strb_t write_strb;
  logic aw_have;
  logic w_have;
  logic ar_fire;
  logic aw_fire;
  logic w_fire;
  logic read_done;
  logic write_commit;

  lsu_pkg::data_t mem [lsu_pkg::MEM_WORDS];

  assign bus.arready = state == sram_idle;
  assign bus.awready = (state == sram_idle) || (state == write_collect && !aw_have);
  assign bus.wready = (state == sram_idle) || (state == write_collect && !w_have);

  assign ar_fire = bus.arvalid && bus.arready;
  assign aw_fire = bus.awvalid && bus.awready;
  assign w_fire = bus.wvalid && bus.wready;
  assign read_done = (state == read_wait) && (delay_count == '0);
  assign write_commit = (state == write_collect) && aw_have && w_have;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= sram_idle;
      delay_count <= '0;
      aw_have <= 1'b0;
      w_have <= 1'b0;
      bus.rvalid <= 1'b0;
      bus.bvalid <= 1'b0;
    end else begin
      if (aw_fire) begin
        aw_have <= 1'b1;
      end
      if (w_fire) begin
        w_have <= 1'b1;
      end
      case (state)
        sram_idle: begin
          if (ar_fire) begin
            delay_count <= $bits(delay_count)'(lsu_pkg::READ_LATENCY - 1);
            state <= read_wait;
          end else if (aw_fire || w_fire) begin
            state <= write_collect; // Address and data may come in either order.
          end
        end
        read_wait: begin
          if (read_done) begin
            bus.rvalid <= 1'b1;
            state <= read_resp;
          end else begin
            delay_count <= delay_count - 1'b1;
          end
        end
        read_resp: begin
          if (bus.rready) begin
            bus.rvalid <= 1'b0;
            state <= sram_idle;
          end
        end
        write_collect: begin
          if (write_commit) begin
            aw_have <= 1'b0;
            w_have <= 1'b0;
            bus.bvalid <= 1'b1;
            state <= write_resp;
          end
        end
        write_resp: begin
          if (bus.bready) begin
            bus.bvalid <= 1'b0;
            state <= sram_idle;
          end
        end
        default: state <= sram_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      read_index <= bus.araddr[lsu_pkg::MEM_INDEX_BITS + 1:2];
    end
    if (aw_fire) begin
      write_index <= bus.awaddr[lsu_pkg::MEM_INDEX_BITS + 1:2];
    end
    if (w_fire) begin
      write_data <= bus.wdata;
      write_strb <= bus.wstrb;
    end
    if (read_done) begin
      bus.rdata <= mem[read_index];
    end
    if (write_commit) begin
      for (int lane = 0; lane < $bits(lsu_pkg::strb_t); lane++) begin
        if (write_strb[lane]) begin
          mem[write_index][lane * 8 +: 8] <= write_data[lane * 8 +: 8];
        end
      end
    end
  end

endmodule

// ==== source/data_memory_top.sv ====
`timescale 1ns/1ps

module data_memory_top (
  input logic clock,
  input logic reset,
  input logic req_valid,
  output logic req_ready,
  input lsu_pkg::addr_t req_addr,
  input lsu_pkg::access_size_t req_size,
  input logic req_signed,
  input logic req_write,
  input lsu_pkg::data_t req_wdata,
  output logic resp_valid,
  output lsu_pkg::data_t resp_rdata
);

  axi_bus_if axi_bus_if_i (
    .clock(clock)
  );

  load_store_unit load_store_unit_i (
    .clock(clock),
    .reset(reset),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .req_addr(req_addr),
    .req_size(req_size),
    .req_signed(req_signed),
    .req_write(req_write),
    .req_wdata(req_wdata),
    .resp_valid(resp_valid),
    .resp_rdata(resp_rdata),
    .bus(axi_bus_if_i.master)
  );

  axi_sram axi_sram_i (
    .clock(clock),
    .reset(reset),
    .bus(axi_bus_if_i.slave)
  );

endmodule

// ==== verification/lsu_properties.sv ====
`timescale 1ns/1ps

module lsu_properties (
  input logic clock,
  input logic reset,
  input logic req_valid,
  input logic req_ready,
  input logic req_write,
  input logic resp_valid,
  input logic arvalid,
  input logic arready,
  input lsu_pkg::addr_t araddr,
  input logic rvalid,
  input logic rready,
  input lsu_pkg::data_t rdata,
  input logic awvalid,
  input logic awready,
  input lsu_pkg::addr_t awaddr,
  input logic wvalid,
  input logic wready,
  input lsu_pkg::data_t wdata,
  input lsu_pkg::strb_t wstrb,
  input logic bvalid,
  input logic bready
);

  int failure_count = 0; // Counts failed properties for the testbench.

  ar_hold: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
      $error("arvalid dropped or araddr changed before arready.");
      failure_count++;
    end

  aw_hold: assert property (@(posedge clock) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else begin
      $error("awvalid dropped or awaddr changed before awready.");
      failure_count++;
    end

  w_hold: assert property (@(posedge clock) disable iff (reset)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
    else begin
      $error("wvalid dropped or write data changed before wready.");
      failure_count++;
    end

  r_hold: assert property (@(posedge clock) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
      $error("rvalid dropped or rdata changed before rready.");
      failure_count++;
    end

  b_hold: assert property (@(posedge clock) disable iff (reset)
    bvalid && !bready |=> bvalid)
    else begin
      $error("bvalid dropped before bready.");
      failure_count++;
    end

  one_in_flight: assert property (@(posedge clock) disable iff (reset)
    !((arvalid || rvalid) && (awvalid || wvalid || bvalid)))
    else begin
      $error("A read and a write are in flight together.");
      failure_count++;
    end

  // Ready stays low from acceptance until the edge where the response is seen.
  ready_low: assert property (@(posedge clock) disable iff (reset)
    ((req_valid && req_ready) || (!req_ready && !rvalid && !bvalid)) |=> !req_ready)
    else begin
      $error("req_ready rose before the unit returned to idle.");
      failure_count++;
    end

  // A store accepted in a response cycle answers in the very next one.
  resp_pulse: assert property (@(posedge clock) disable iff (reset)
    resp_valid && !(req_valid && req_ready && req_write) |=> !resp_valid)
    else begin
      $error("resp_valid was high for more than one cycle.");
      failure_count++;
    end

endmodule

bind load_store_unit lsu_properties lsu_properties_i (
  .clock(clock), .reset(reset), .req_valid(req_valid), .req_ready(req_ready),
  .req_write(req_write), .resp_valid(resp_valid),
  .arvalid(bus.arvalid), .arready(bus.arready), .araddr(bus.araddr),
  .rvalid(bus.rvalid), .rready(bus.rready), .rdata(bus.rdata),
  .awvalid(bus.awvalid), .awready(bus.awready), .awaddr(bus.awaddr),
  .wvalid(bus.wvalid), .wready(bus.wready), .wdata(bus.wdata), .wstrb(bus.wstrb),
  .bvalid(bus.bvalid), .bready(bus.bready)
);

// ==== verification/data_memory_tb.sv ====
`timescale 1ns/1ps

module data_memory_tb;

  logic clock;
  logic reset;
  logic req_valid;
  logic req_ready;
  lsu_pkg::addr_t req_addr;
  lsu_pkg::access_size_t req_size;
  logic req_signed;
  logic req_write;
  lsu_pkg::data_t req_wdata;
  logic resp_valid;
  lsu_pkg::data_t resp_rdata;

  logic [7:0] model_mem [1024]; // Byte image of the SRAM.
  logic [31:0] lcg_state = 32'hdedc_a9f5;
  int outstanding;
  logic last_resp;

  data_memory_top data_memory_top_i (
    .clock(clock),
    .reset(reset),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .req_addr(req_addr),
    .req_size(req_size),
    .req_signed(req_signed),
    .req_write(req_write),
    .req_wdata(req_wdata),
    .resp_valid(resp_valid),
    .resp_rdata(resp_rdata)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic report_failure();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic fail_with(input string what);
    $display("%s", what);
    report_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got === expected) else begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, expected);
      report_failure();
    end
  endtask

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Random address inside 1 KiB, aligned to the access size.
  function automatic lsu_pkg::addr_t aligned_address(input lsu_pkg::access_size_t size);
    logic [31:0] r;
    r = next_random();
    return {22'h0, r[23:14]} & ~((32'd1 << size) - 32'd1);
  endfunction

  function automatic lsu_pkg::data_t expected_load(input lsu_pkg::addr_t addr,
                                                   input lsu_pkg::access_size_t size,
                                                   input logic sign);
    logic [9:0] a;
    logic [7:0] b0, b1, b2, b3;
    a = addr[9:0];
    b0 = model_mem[a];
    b1 = model_mem[a + 10'd1];
    b2 = model_mem[a + 10'd2];
    b3 = model_mem[a + 10'd3];
    case (size)
      2'd0: return sign ? {{24{b0[7]}}, b0} : {24'h0, b0};
      2'd1: return sign ? {{16{b1[7]}}, b1, b0} : {16'h0, b1, b0};
      default: return {b3, b2, b1, b0}; // Little-endian word.
    endcase
  endfunction

  task automatic store_model(input lsu_pkg::addr_t addr, input lsu_pkg::access_size_t size,
                             input lsu_pkg::data_t wdata);
    for (int i = 0; i < (1 << size); i++) begin
      model_mem[addr[9:0] + i] = wdata[i * 8 +: 8];
    end
  endtask

  task automatic wait_for_ready();
    int cycles;
    cycles = 0;
    while (!req_ready) begin
      @(posedge clock);
      #2;
      cycles++;
      assert (cycles < 100) else fail_with("Timeout while waiting for req_ready.");
    end
  endtask

  task automatic run_access(input logic write, input lsu_pkg::addr_t addr,
                            input lsu_pkg::access_size_t size, input logic sign,
                            input lsu_pkg::data_t wdata);
    int cycles;
    wait_for_ready();
    req_valid = 1'b1;
    req_write = write;
    req_addr = addr;
    req_size = size;
    req_signed = sign;
    req_wdata = wdata;
    @(posedge clock);
    #2;
    req_valid = 1'b0; // Accepted on the edge just passed.
    check_value("req_ready", req_ready, 32'd0);
    if (write) begin
      check_value("resp_valid", resp_valid, 32'd1);
      store_model(addr, size, wdata);
      @(posedge clock);
      #2;
      check_value("resp_valid", resp_valid, 32'd0);
    end else begin
      cycles = 0;
      while (!resp_valid) begin
        @(posedge clock);
        #2;
        cycles++;
        assert (cycles < 100) else fail_with("Timeout while waiting for resp_valid.");
      end
      check_value("req_ready", req_ready, 32'd1);
      check_value("resp_rdata", resp_rdata, expected_load(addr, size, sign));
    end
  endtask

  // Every response must follow an accepted request and last one cycle.
  always @(negedge clock) begin
    if (reset) begin
      outstanding = 0;
      last_resp = 1'b0;
    end else begin
      assert (data_memory_top_i.load_store_unit_i.lsu_properties_i.failure_count == 0)
        else fail_with("A bus or handshake property failed.");
      if (resp_valid) begin
        assert (!last_resp) else fail_with("resp_valid stayed high for more than one cycle.");
        assert (outstanding > 0) else fail_with("resp_valid rose without an accepted request.");
        outstanding--;
      end
      // A store accepted in a response cycle answers in the next one.
      last_resp = resp_valid && !(req_valid && req_ready);
      if (req_valid && req_ready) begin
        outstanding++;
      end
    end
  end

  initial begin
    lsu_pkg::addr_t base;
    lsu_pkg::access_size_t size;
    lsu_pkg::data_t data;
    logic [31:0] r;
    reset = 1'b1;
    req_valid = 1'b0;
    req_addr = '0;
    req_size = '0;
    req_signed = 1'b0;
    req_write = 1'b0;
    req_wdata = '0;
    repeat (5) @(posedge clock);
    #2;
    reset = 1'b0;
    check_value("req_ready", req_ready, 32'd1);
    check_value("resp_valid", resp_valid, 32'd0);

    for (int w = 0; w < lsu_pkg::MEM_WORDS; w++) begin
      data = next_random();
      run_access(1'b1, w * 4, 2'd2, 1'b0, data);
    end
    for (int w = 0; w < lsu_pkg::MEM_WORDS; w++) begin
      run_access(1'b0, w * 4, 2'd2, 1'b0, '0);
    end

    // Narrow stores at each lane offset, checked with word loads.
    for (int i = 0; i < 64; i++) begin
      base = aligned_address(2'd2);
      data = next_random();
      run_access(1'b1, base + (i % 4), 2'd0, 1'b0, data);
      run_access(1'b0, base, 2'd2, 1'b0, '0);
      data = next_random();
      run_access(1'b1, base + ((i / 4) % 2) * 2, 2'd1, 1'b0, data);
      run_access(1'b0, base, 2'd2, 1'b0, '0);
    end

    for (int i = 0; i < 200; i++) begin
      size = lsu_pkg::access_size_t'(i % 2);
      base = aligned_address(size);
      data = next_random();
      if ((i / 2) % 2 == 1) begin
        data[size * 8 + 7] = 1'b1; // Negative element.
      end
      run_access(1'b1, base, size, 1'b0, data);
      run_access(1'b0, base, size, ((i / 4) % 2) == 1, '0);
    end

    for (int i = 0; i < 2000; i++) begin
      r = next_random();
      size = lsu_pkg::access_size_t'(r[15:0] % 3);
      base = aligned_address(size);
      data = next_random();
      run_access(r[31], base, size, r[30], data);
    end

    @(posedge clock);
    #2;
    if (data_memory_top_i.load_store_unit_i.lsu_properties_i.failure_count == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      fail_with("A bus or handshake property failed.");
    end
  end

endmodule

// ==== compile.f ====
source/lsu_pkg.sv
source/axi_bus_if.sv
source/load_store_unit.sv
source/axi_sram.sv
source/data_memory_top.sv
verification/lsu_properties.sv
verification/data_memory_tb.sv
